// File: exu_pkg.sv
`default_nettype none

package exu_pkg;

  // instruction class as handed over by decode
  typedef enum logic [3:0] {
    OP_ALU    = 4'd0,
    OP_BRANCH = 4'd1,
    OP_JUMP   = 4'd2,
    OP_LOAD   = 4'd3,
    OP_STORE  = 4'd4,
    OP_CSR    = 4'd5,
    OP_ECALL  = 4'd6,
    OP_MRET   = 4'd7,
    OP_EBREAK = 4'd8
  } op_class_e;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_SGE  = 4'd10,
    ALU_SGEU = 4'd11
  } alu_op_e;

  // immediate forms arrive with src1 already formed
  typedef enum logic [1:0] {
    CSR_RW = 2'd0,
    CSR_RS = 2'd1,
    CSR_RC = 2'd2
  } csr_op_e;

  typedef logic [11:0] csr_addr_t;
  typedef logic [4:0]  reg_idx_t;

  localparam csr_addr_t CSR_MSTATUS = 12'h300;
  localparam csr_addr_t CSR_MTVEC   = 12'h305;
  localparam csr_addr_t CSR_MEPC    = 12'h341;
  localparam csr_addr_t CSR_MCAUSE  = 12'h342;

  // environment call from M-mode
  localparam int MCAUSE_ECALL = 11;

  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;

  // x0 never gets written
  localparam reg_idx_t REG_ZERO = 5'd0;

endpackage

`default_nettype wire

// File: exu_ifs.sv
`timescale 1ns/10ps
`default_nettype none

// one outstanding word access between stage and data memory
interface mem_req_if #(
  parameter int XLEN = 64
);
  logic            req_valid;
  logic            req_wen;
  logic [XLEN-1:0] addr;
  logic [XLEN-1:0] wdata;
  logic            resp_valid;
  logic [XLEN-1:0] rdata;

  modport stage (
    output req_valid, req_wen, addr, wdata,
    input  resp_valid, rdata
  );

  modport mem (
    input  req_valid, req_wen, addr, wdata,
    output resp_valid, rdata
  );
endinterface

interface csr_if #(
  parameter int XLEN = 64
);
  logic                 wen;
  exu_pkg::csr_addr_t   waddr;
  logic [XLEN-1:0]      wdata;
  logic                 ecall;
  logic [XLEN-1:0]      epc;
  logic [XLEN-1:0]      rdata;
  exu_pkg::csr_addr_t   raddr;
  logic [XLEN-1:0]      mepc;
  logic [XLEN-1:0]      mtvec;

  modport ctrl (
    output wen, waddr, wdata, ecall, epc, raddr,
    input  rdata, mepc, mtvec
  );

  modport regs (
    input  wen, waddr, wdata, ecall, epc, raddr,
    output rdata, mepc, mtvec
  );
endinterface

`default_nettype wire

// File: exu_alu.sv
`timescale 1ns/10ps
`default_nettype none

module exu_alu #(
  parameter int XLEN = 64
) (
  input  wire logic [XLEN-1:0] a_i,
  input  wire logic [XLEN-1:0] b_i,
  input  wire exu_pkg::alu_op_e op_i,
  output logic      [XLEN-1:0] res_o
);

  localparam int SHW = $clog2(XLEN);

  logic [SHW-1:0] shamt;
  logic           lt_s;
  logic           lt_u;

  // shift amount from low bits of b only
  assign shamt = b_i[SHW-1:0];
  assign lt_s  = $signed(a_i) < $signed(b_i);
  assign lt_u  = a_i < b_i;

  always_comb begin
    case (op_i)
      exu_pkg::ALU_ADD:  res_o = a_i + b_i;
      exu_pkg::ALU_SUB:  res_o = a_i - b_i;
      exu_pkg::ALU_AND:  res_o = a_i & b_i;
      exu_pkg::ALU_OR:   res_o = a_i | b_i;
      exu_pkg::ALU_XOR:  res_o = a_i ^ b_i;
      exu_pkg::ALU_SLL:  res_o = a_i << shamt;
      exu_pkg::ALU_SRL:  res_o = a_i >> shamt;
      exu_pkg::ALU_SRA:  res_o = $signed(a_i) >>> shamt;
      exu_pkg::ALU_SLT:  res_o = XLEN'(lt_s);
      exu_pkg::ALU_SLTU: res_o = XLEN'(lt_u);
      exu_pkg::ALU_SGE:  res_o = XLEN'(!lt_s);
      exu_pkg::ALU_SGEU: res_o = XLEN'(!lt_u);
      default:           res_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: exu_csr_file.sv
`timescale 1ns/10ps
`default_nettype none

module exu_csr_file #(
  parameter int XLEN = 64
) (
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic commit_i,
  csr_if.regs       csr
);

  logic [XLEN-1:0] mstatus;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] mcause;

  // unknown addresses read as zero
  always_comb begin
    case (csr.raddr)
      exu_pkg::CSR_MSTATUS: csr.rdata = mstatus;
      exu_pkg::CSR_MTVEC:   csr.rdata = mtvec;
      exu_pkg::CSR_MEPC:    csr.rdata = mepc;
      exu_pkg::CSR_MCAUSE:  csr.rdata = mcause;
      default:              csr.rdata = '0;
    endcase
  end

  assign csr.mepc  = mepc;
  assign csr.mtvec = mtvec;

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (commit_i) begin
      if (csr.ecall) begin
        mepc   <= csr.epc;
        mcause <= XLEN'(exu_pkg::MCAUSE_ECALL);
      end else if (csr.wen) begin
        case (csr.waddr)
          exu_pkg::CSR_MSTATUS: mstatus <= csr.wdata;
          exu_pkg::CSR_MTVEC:   mtvec   <= csr.wdata;
          exu_pkg::CSR_MEPC:    mepc    <= csr.wdata;
          exu_pkg::CSR_MCAUSE:  mcause  <= csr.wdata;
          // writes elsewhere are dropped
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: exu_ctrl_flow.sv
`timescale 1ns/10ps
`default_nettype none

module exu_ctrl_flow #(
  parameter int XLEN = 64
) (
  input  wire logic                clk,
  input  wire exu_pkg::op_class_e  class_i,
  input  wire exu_pkg::csr_op_e    csr_op_i,
  input  wire exu_pkg::alu_op_e    alu_op_i,
  input  wire logic [XLEN-1:0]     alu_res_i,
  input  wire logic [XLEN-1:0]     src1_i,
  input  wire logic [XLEN-1:0]     pc_i,
  input  wire logic [XLEN-1:0]     target_i,
  input  wire exu_pkg::csr_addr_t  csr_addr_i,
  csr_if.ctrl                      csr,
  output logic                     redirect_o,
  output logic [XLEN-1:0]          npc_o,
  output logic                     ebreak_o
);

  logic            taken;
  logic [XLEN-1:0] mret_status;

  // beq uses sub, everything else is a set-style compare
  assign taken = (alu_op_i == exu_pkg::ALU_SUB) ? (alu_res_i == '0) : (alu_res_i != '0);

  // mret has to see the old mstatus
  assign csr.raddr = (class_i == exu_pkg::OP_MRET) ? exu_pkg::CSR_MSTATUS : csr_addr_i;
  assign csr.epc   = pc_i;

  always_comb begin
    mret_status = csr.rdata;
    mret_status[exu_pkg::MSTATUS_MIE_BIT]  = csr.rdata[exu_pkg::MSTATUS_MPIE_BIT];
    mret_status[exu_pkg::MSTATUS_MPIE_BIT] = 1'b1;
  end

  always_comb begin
    csr.wen    = 1'b0;
    csr.waddr  = csr_addr_i;
    csr.wdata  = src1_i;
    csr.ecall  = 1'b0;
    redirect_o = 1'b0;
    npc_o      = target_i;
    ebreak_o   = 1'b0;
    case (class_i)
      exu_pkg::OP_BRANCH: redirect_o = taken;
      exu_pkg::OP_JUMP:   redirect_o = 1'b1;
      exu_pkg::OP_CSR: begin
        csr.wen = 1'b1;
        case (csr_op_i)
          exu_pkg::CSR_RS: csr.wdata = csr.rdata | src1_i;
          exu_pkg::CSR_RC: csr.wdata = csr.rdata & ~src1_i;
          default:         csr.wdata = src1_i;
        endcase
      end
      exu_pkg::OP_ECALL: begin
        csr.ecall  = 1'b1;
        redirect_o = 1'b1;
        npc_o      = csr.mtvec;
      end
      exu_pkg::OP_MRET: begin
        csr.wen    = 1'b1;
        csr.waddr  = exu_pkg::CSR_MSTATUS;
        csr.wdata  = mret_status;
        redirect_o = 1'b1;
        npc_o      = csr.mepc;
      end
      exu_pkg::OP_EBREAK: ebreak_o = 1'b1;
      default: ;
    endcase
  end

  a_csr_wen_class: assert property (@(posedge clk)
    csr.wen |-> (class_i inside {exu_pkg::OP_CSR, exu_pkg::OP_ECALL, exu_pkg::OP_MRET}));

endmodule

`default_nettype wire

// File: exu_stage.sv
`timescale 1ns/10ps
`default_nettype none

module exu_stage #(
  parameter int XLEN = 64
) (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic                in_valid_i,
  output logic                     in_ready_o,
  input  wire exu_pkg::op_class_e  op_class_i,
  input  wire exu_pkg::alu_op_e    alu_op_i,
  input  wire exu_pkg::csr_op_e    csr_op_i,
  input  wire logic [XLEN-1:0]     src1_i,
  input  wire logic [XLEN-1:0]     src2_i,
  input  wire logic [XLEN-1:0]     imm_i,
  input  wire logic [XLEN-1:0]     pc_i,
  input  wire logic [XLEN-1:0]     base_i,
  input  wire exu_pkg::csr_addr_t  csr_addr_i,
  input  wire exu_pkg::reg_idx_t   rd_i,
  output logic                     out_valid_o,
  input  wire logic                out_ready_i,
  output exu_pkg::reg_idx_t        rd_o,
  output logic                     rd_wen_o,
  output logic [XLEN-1:0]          rd_wdata_o,
  output logic                     redirect_o,
  output logic [XLEN-1:0]          npc_o,
  output logic                     ebreak_o,
  mem_req_if.stage                 mem
);

  exu_pkg::op_class_e class_q;
  exu_pkg::alu_op_e   alu_op_q;
  exu_pkg::csr_op_e   csr_op_q;
  exu_pkg::csr_addr_t csr_addr_q;
  logic [XLEN-1:0]    src1_q;
  logic [XLEN-1:0]    src2_q;
  logic [XLEN-1:0]    pc_q;
  logic [XLEN-1:0]    target_q;
  logic [XLEN-1:0]    load_q;
  logic [XLEN-1:0]    alu_res;
  logic               mem_pend;
  logic               accept;
  logic               is_mem;
  logic               commit;

  csr_if #(.XLEN(XLEN)) csr_bus ();

  assign accept = in_valid_i & in_ready_o;
  assign commit = out_valid_o & out_ready_i;
  assign is_mem = (op_class_i == exu_pkg::OP_LOAD) || (op_class_i == exu_pkg::OP_STORE);
  // back-to-back accept when the held result leaves this cycle
  assign in_ready_o = ~mem_pend & (~out_valid_o | out_ready_i);

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid_o <= 1'b0;
      mem_pend    <= 1'b0;
      class_q     <= exu_pkg::OP_ALU;
    end else begin
      if (commit) begin
        out_valid_o <= 1'b0;
      end
      if (accept) begin
        class_q <= op_class_i;
        if (is_mem) begin
          mem_pend <= 1'b1;
        end else begin
          out_valid_o <= 1'b1;
        end
      end
      if (mem_pend && mem.resp_valid) begin
        mem_pend    <= 1'b0;
        out_valid_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      alu_op_q   <= alu_op_i;
      csr_op_q   <= csr_op_i;
      csr_addr_q <= csr_addr_i;
      src1_q     <= src1_i;
      src2_q     <= src2_i;
      pc_q       <= pc_i;
      target_q   <= base_i + imm_i;
      rd_o       <= rd_i;
    end
    if (mem_pend && mem.resp_valid && class_q == exu_pkg::OP_LOAD) begin
      load_q <= mem.rdata;
    end
  end

  assign mem.req_valid = mem_pend;
  assign mem.req_wen   = (class_q == exu_pkg::OP_STORE);
  assign mem.addr      = target_q;
  assign mem.wdata     = src2_q;

  exu_alu #(.XLEN(XLEN)) u_alu (
    .a_i   (src1_q),
    .b_i   (src2_q),
    .op_i  (alu_op_q),
    .res_o (alu_res)
  );

  exu_ctrl_flow #(.XLEN(XLEN)) u_ctrl_flow (
    .clk        (clk),
    .class_i    (class_q),
    .csr_op_i   (csr_op_q),
    .alu_op_i   (alu_op_q),
    .alu_res_i  (alu_res),
    .src1_i     (src1_q),
    .pc_i       (pc_q),
    .target_i   (target_q),
    .csr_addr_i (csr_addr_q),
    .csr        (csr_bus.ctrl),
    .redirect_o (redirect_o),
    .npc_o      (npc_o),
    .ebreak_o   (ebreak_o)
  );

  exu_csr_file #(.XLEN(XLEN)) u_csr_file (
    .clk      (clk),
    .rst      (rst),
    .commit_i (commit),
    .csr      (csr_bus.regs)
  );

  // csr returns the value before its own write
  always_comb begin
    case (class_q)
      exu_pkg::OP_LOAD: rd_wdata_o = load_q;
      exu_pkg::OP_CSR:  rd_wdata_o = csr_bus.rdata;
      default:          rd_wdata_o = alu_res;
    endcase
  end

  assign rd_wen_o = (rd_o != exu_pkg::REG_ZERO) &&
                    (class_q inside {exu_pkg::OP_ALU, exu_pkg::OP_JUMP,
                                     exu_pkg::OP_LOAD, exu_pkg::OP_CSR});

  a_hold_result: assert property (@(posedge clk) disable iff (rst)
    (out_valid_o && !out_ready_i) |=>
      (out_valid_o && $stable(rd_o) && $stable(rd_wen_o) && $stable(rd_wdata_o) &&
       $stable(redirect_o) && $stable(npc_o) && $stable(ebreak_o)));

endmodule

`default_nettype wire

// File: exu_data_mem.sv
`timescale 1ns/10ps
`default_nettype none

module exu_data_mem #(
  parameter int XLEN      = 64,
  parameter int MEM_DEPTH = 256,
  parameter int MEM_LAT   = 2
) (
  input  wire logic clk,
  input  wire logic rst,
  mem_req_if.mem    bus
);

  localparam int OFF  = $clog2(XLEN / 8);
  localparam int IDXW = $clog2(MEM_DEPTH);
  localparam int CW   = $clog2(MEM_LAT + 1);

  logic [XLEN-1:0] ram [MEM_DEPTH];
  logic [IDXW-1:0] idx;
  logic [CW-1:0]   cnt;
  logic [CW-1:0]   cnt_cur;
  logic            active;
  logic            start;
  logic            fire;

  initial begin
    for (int i = 0; i < MEM_DEPTH; i++) begin
      ram[i] = '0;
    end
  end

  // word index, wraps at the memory size
  assign idx = bus.addr[OFF +: IDXW];

  // req stays up through the response cycle, so ignore it there
  assign start   = bus.req_valid & ~active & ~bus.resp_valid;
  assign cnt_cur = start ? CW'(MEM_LAT - 1) : cnt;
  assign fire    = (start | active) & (cnt_cur == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      active         <= 1'b0;
      cnt            <= '0;
      bus.resp_valid <= 1'b0;
    end else begin
      bus.resp_valid <= fire;
      if (fire) begin
        active <= 1'b0;
      end else if (start | active) begin
        active <= 1'b1;
        cnt    <= cnt_cur - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire && bus.req_wen) begin
      ram[idx] <= bus.wdata;
    end
    if (fire && !bus.req_wen) begin
      bus.rdata <= ram[idx];
    end
  end

  a_req_stable: assert property (@(posedge clk) disable iff (rst)
    (bus.req_valid && !bus.resp_valid) |=> ($stable(bus.addr) && $stable(bus.req_wen)));

endmodule

`default_nettype wire

// File: exu_top.sv
`timescale 1ns/10ps
`default_nettype none

module exu_top #(
  parameter int XLEN      = 64,
  parameter int MEM_DEPTH = 256,
  parameter int MEM_LAT   = 2
) (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic                in_valid_i,
  output logic                     in_ready_o,
  input  wire exu_pkg::op_class_e  op_class_i,
  input  wire exu_pkg::alu_op_e    alu_op_i,
  input  wire exu_pkg::csr_op_e    csr_op_i,
  input  wire logic [XLEN-1:0]     src1_i,
  input  wire logic [XLEN-1:0]     src2_i,
  input  wire logic [XLEN-1:0]     imm_i,
  input  wire logic [XLEN-1:0]     pc_i,
  input  wire logic [XLEN-1:0]     base_i,
  input  wire exu_pkg::csr_addr_t  csr_addr_i,
  input  wire exu_pkg::reg_idx_t   rd_i,
  output logic                     out_valid_o,
  input  wire logic                out_ready_i,
  output exu_pkg::reg_idx_t        rd_o,
  output logic                     rd_wen_o,
  output logic [XLEN-1:0]          rd_wdata_o,
  output logic                     redirect_o,
  output logic [XLEN-1:0]          npc_o,
  output logic                     ebreak_o
);

  mem_req_if #(.XLEN(XLEN)) mem_bus ();

  exu_stage #(.XLEN(XLEN)) u_stage (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .op_class_i  (op_class_i),
    .alu_op_i    (alu_op_i),
    .csr_op_i    (csr_op_i),
    .src1_i      (src1_i),
    .src2_i      (src2_i),
    .imm_i       (imm_i),
    .pc_i        (pc_i),
    .base_i      (base_i),
    .csr_addr_i  (csr_addr_i),
    .rd_i        (rd_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .rd_o        (rd_o),
    .rd_wen_o    (rd_wen_o),
    .rd_wdata_o  (rd_wdata_o),
    .redirect_o  (redirect_o),
    .npc_o       (npc_o),
    .ebreak_o    (ebreak_o),
    .mem         (mem_bus.stage)
  );

  exu_data_mem #(
    .XLEN      (XLEN),
    .MEM_DEPTH (MEM_DEPTH),
    .MEM_LAT   (MEM_LAT)
  ) u_data_mem (
    .clk (clk),
    .rst (rst),
    .bus (mem_bus.mem)
  );

endmodule

`default_nettype wire

// File: tb_exu.sv
`timescale 1ns/10ps
`default_nettype none

module tb_exu;

  localparam int XLEN        = 64;
  localparam int MEM_DEPTH   = 256;
  localparam int MEM_LAT     = 2;
  localparam int SHW         = $clog2(XLEN);
  localparam int NUM_INSTR   = 400;
  localparam int RST_CYCLES  = 4;
  localparam int CLK_PERIOD  = 40;
  localparam int WATCHDOG_NS = (NUM_INSTR * (MEM_LAT + 10) + RST_CYCLES) * CLK_PERIOD;

  typedef logic [XLEN-1:0] word_t;

  logic               clk;
  logic               rst;
  logic               in_valid_i;
  logic               in_ready_o;
  exu_pkg::op_class_e op_class_i;
  exu_pkg::alu_op_e   alu_op_i;
  exu_pkg::csr_op_e   csr_op_i;
  word_t              src1_i;
  word_t              src2_i;
  word_t              imm_i;
  word_t              pc_i;
  word_t              base_i;
  exu_pkg::csr_addr_t csr_addr_i;
  exu_pkg::reg_idx_t  rd_i;
  logic               out_valid_o;
  logic               out_ready_i;
  exu_pkg::reg_idx_t  rd_o;
  logic               rd_wen_o;
  word_t              rd_wdata_o;
  logic               redirect_o;
  word_t              npc_o;
  logic               ebreak_o;

  int    seed = 32'h5ae8cf35;
  word_t mem_model [64];
  word_t m_status;
  word_t m_tvec;
  word_t m_epc;
  word_t m_cause;

  // expected results in issue order
  exu_pkg::reg_idx_t exp_rd [$];
  logic              exp_wen [$];
  word_t             exp_wdata [$];
  logic              exp_redir [$];
  word_t             exp_npc [$];
  logic              exp_ebreak [$];
  string             exp_name [$];

  int   generated;
  int   accepted;
  int   retired;
  int   extra;
  logic held;

  exu_top #(
    .XLEN      (XLEN),
    .MEM_DEPTH (MEM_DEPTH),
    .MEM_LAT   (MEM_LAT)
  ) UUT (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .op_class_i  (op_class_i),
    .alu_op_i    (alu_op_i),
    .csr_op_i    (csr_op_i),
    .src1_i      (src1_i),
    .src2_i      (src2_i),
    .imm_i       (imm_i),
    .pc_i        (pc_i),
    .base_i      (base_i),
    .csr_addr_i  (csr_addr_i),
    .rd_i        (rd_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .rd_o        (rd_o),
    .rd_wen_o    (rd_wen_o),
    .rd_wdata_o  (rd_wdata_o),
    .redirect_o  (redirect_o),
    .npc_o       (npc_o),
    .ebreak_o    (ebreak_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired, results stopped arriving from the DUT");
    $display("TEST FAILED");
    $fatal(1, "timeout");
  end

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("ERROR %s expected %h actual %h", name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic check_idx(input string name, input exu_pkg::reg_idx_t exp,
                           input exu_pkg::reg_idx_t act);
    if (act !== exp) begin
      $display("ERROR %s expected %0d actual %0d", name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "index mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR %s expected %b actual %b", name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "flag mismatch");
    end
  endtask

  function automatic word_t alu_model(input word_t a, input word_t b,
                                      input exu_pkg::alu_op_e op);
    logic lt_s;
    logic lt_u;
    lt_s = $signed(a) < $signed(b);
    lt_u = a < b;
    case (op)
      exu_pkg::ALU_ADD:  return a + b;
      exu_pkg::ALU_SUB:  return a - b;
      exu_pkg::ALU_AND:  return a & b;
      exu_pkg::ALU_OR:   return a | b;
      exu_pkg::ALU_XOR:  return a ^ b;
      exu_pkg::ALU_SLL:  return a << b[SHW-1:0];
      exu_pkg::ALU_SRL:  return a >> b[SHW-1:0];
      exu_pkg::ALU_SRA:  return $signed(a) >>> b[SHW-1:0];
      exu_pkg::ALU_SLT:  return {{(XLEN-1){1'b0}}, lt_s};
      exu_pkg::ALU_SLTU: return {{(XLEN-1){1'b0}}, lt_u};
      exu_pkg::ALU_SGE:  return {{(XLEN-1){1'b0}}, !lt_s};
      exu_pkg::ALU_SGEU: return {{(XLEN-1){1'b0}}, !lt_u};
      default:           return '0;
    endcase
  endfunction

  function automatic word_t csr_read(input exu_pkg::csr_addr_t addr);
    case (addr)
      exu_pkg::CSR_MSTATUS: return m_status;
      exu_pkg::CSR_MTVEC:   return m_tvec;
      exu_pkg::CSR_MEPC:    return m_epc;
      exu_pkg::CSR_MCAUSE:  return m_cause;
      default:              return '0;
    endcase
  endfunction

  task automatic csr_write(input exu_pkg::csr_addr_t addr, input word_t val);
    case (addr)
      exu_pkg::CSR_MSTATUS: m_status = val;
      exu_pkg::CSR_MTVEC:   m_tvec = val;
      exu_pkg::CSR_MEPC:    m_epc = val;
      exu_pkg::CSR_MCAUSE:  m_cause = val;
      default: ;
    endcase
  endtask

  // pick one instruction, update the model and drive it
  task automatic drive_next_instr();
    exu_pkg::op_class_e cls;
    exu_pkg::alu_op_e   aop;
    exu_pkg::csr_op_e   cop;
    exu_pkg::csr_addr_t caddr;
    exu_pkg::reg_idx_t  rd;
    word_t              a;
    word_t              b;
    word_t              imm;
    word_t              pc;
    word_t              base;
    word_t              old;
    word_t              res;
    word_t              wdata;
    word_t              npc;
    logic               wen;
    logic               redir;
    int                 r;
    int                 w;
    r     = {$random(seed)} % 16;
    w     = {$random(seed)} % 64;
    a     = {$random(seed), $random(seed)};
    b     = {$random(seed), $random(seed)};
    pc    = {$random(seed), $random(seed)} & ~word_t'(3);
    base  = {$random(seed), $random(seed)};
    imm   = {$random(seed), $random(seed)};
    rd    = ({$random(seed)} % 8 == 0) ? exu_pkg::REG_ZERO : exu_pkg::reg_idx_t'($random(seed));
    aop   = exu_pkg::ALU_ADD;
    cop   = exu_pkg::csr_op_e'(2'({$random(seed)} % 3));
    caddr = exu_pkg::CSR_MSTATUS;
    if (r < 5) begin
      cls = exu_pkg::OP_ALU;
      aop = exu_pkg::alu_op_e'(4'({$random(seed)} % 12));
    end else if (r < 7) begin
      cls = exu_pkg::OP_BRANCH;
      case ({$random(seed)} % 6)
        0:       aop = exu_pkg::ALU_SUB;
        1:       aop = exu_pkg::ALU_XOR;
        2:       aop = exu_pkg::ALU_SLT;
        3:       aop = exu_pkg::ALU_SLTU;
        4:       aop = exu_pkg::ALU_SGE;
        default: aop = exu_pkg::ALU_SGEU;
      endcase
      // equal operands hit the boundary of every compare
      if ($random(seed) & 1) b = a;
    end else if (r == 7) begin
      cls = exu_pkg::OP_JUMP;
      a   = pc;
      b   = word_t'(4);
    end else if (r < 12) begin
      cls = (r < 10) ? exu_pkg::OP_LOAD : exu_pkg::OP_STORE;
      imm = word_t'(w * (XLEN / 8)) - base;
    end else if (r < 14) begin
      cls = exu_pkg::OP_CSR;
      case ({$random(seed)} % 5)
        0:       caddr = exu_pkg::CSR_MSTATUS;
        1:       caddr = exu_pkg::CSR_MTVEC;
        2:       caddr = exu_pkg::CSR_MEPC;
        3:       caddr = exu_pkg::CSR_MCAUSE;
        default: caddr = 12'h7c0;
      endcase
    end else if (r == 14) begin
      cls = exu_pkg::OP_ECALL;
    end else begin
      cls = ($random(seed) & 1) ? exu_pkg::OP_MRET : exu_pkg::OP_EBREAK;
    end

    res   = alu_model(a, b, aop);
    wdata = res;
    wen   = 1'b0;
    redir = 1'b0;
    npc   = base + imm;
    case (cls)
      exu_pkg::OP_ALU:    wen = (rd != exu_pkg::REG_ZERO);
      exu_pkg::OP_BRANCH: redir = (aop == exu_pkg::ALU_SUB) ? (a == b) : (res != '0);
      exu_pkg::OP_JUMP: begin
        wen   = (rd != exu_pkg::REG_ZERO);
        redir = 1'b1;
      end
      exu_pkg::OP_LOAD: begin
        wen   = (rd != exu_pkg::REG_ZERO);
        wdata = mem_model[w];
      end
      exu_pkg::OP_STORE: mem_model[w] = b;
      exu_pkg::OP_CSR: begin
        old   = csr_read(caddr);
        wen   = (rd != exu_pkg::REG_ZERO);
        wdata = old;
        case (cop)
          exu_pkg::CSR_RS: csr_write(caddr, old | a);
          exu_pkg::CSR_RC: csr_write(caddr, old & ~a);
          default:         csr_write(caddr, a);
        endcase
      end
      exu_pkg::OP_ECALL: begin
        redir   = 1'b1;
        npc     = m_tvec;
        m_epc   = pc;
        m_cause = word_t'(exu_pkg::MCAUSE_ECALL);
      end
      exu_pkg::OP_MRET: begin
        redir = 1'b1;
        npc   = m_epc;
        old   = m_status;
        old[exu_pkg::MSTATUS_MIE_BIT]  = m_status[exu_pkg::MSTATUS_MPIE_BIT];
        old[exu_pkg::MSTATUS_MPIE_BIT] = 1'b1;
        m_status = old;
      end
      default: ;
    endcase

    exp_rd.push_back(rd);
    exp_wen.push_back(wen);
    exp_wdata.push_back(wdata);
    exp_redir.push_back(redir);
    exp_npc.push_back(npc);
    exp_ebreak.push_back(cls == exu_pkg::OP_EBREAK);
    exp_name.push_back($sformatf("%s/%s #%0d", cls.name(), aop.name(), generated));
    generated++;

    in_valid_i <= 1'b1;
    op_class_i <= cls;
    alu_op_i   <= aop;
    csr_op_i   <= cop;
    src1_i     <= a;
    src2_i     <= b;
    imm_i      <= imm;
    pc_i       <= pc;
    base_i     <= base;
    csr_addr_i <= caddr;
    rd_i       <= rd;
  endtask

  // every cycle the result is shown it must match the oldest outstanding one
  task automatic check_result();
    if (exp_name.size() == 0) begin
      stop_on_error("DUT presented a result with no instruction outstanding");
    end else begin
      check_idx({exp_name[0], " rd_o"}, exp_rd[0], rd_o);
      check_bit({exp_name[0], " rd_wen_o"}, exp_wen[0], rd_wen_o);
      check_word({exp_name[0], " rd_wdata_o"}, exp_wdata[0], rd_wdata_o);
      check_bit({exp_name[0], " redirect_o"}, exp_redir[0], redirect_o);
      check_bit({exp_name[0], " ebreak_o"}, exp_ebreak[0], ebreak_o);
      if (exp_redir[0]) begin
        check_word({exp_name[0], " npc_o"}, exp_npc[0], npc_o);
      end
    end
  endtask

  task automatic pop_result();
    void'(exp_rd.pop_front());
    void'(exp_wen.pop_front());
    void'(exp_wdata.pop_front());
    void'(exp_redir.pop_front());
    void'(exp_npc.pop_front());
    void'(exp_ebreak.pop_front());
    void'(exp_name.pop_front());
  endtask

  initial begin
    rst         = 1'b1;
    in_valid_i  = 1'b0;
    op_class_i  = exu_pkg::OP_ALU;
    alu_op_i    = exu_pkg::ALU_ADD;
    csr_op_i    = exu_pkg::CSR_RW;
    src1_i      = '0;
    src2_i      = '0;
    imm_i       = '0;
    pc_i        = '0;
    base_i      = '0;
    csr_addr_i  = '0;
    rd_i        = '0;
    out_ready_i = 1'b0;
    m_status    = '0;
    m_tvec      = '0;
    m_epc       = '0;
    m_cause     = '0;
    generated   = 0;
    accepted    = 0;
    retired     = 0;
    extra       = 0;
    held        = 1'b0;
    for (int i = 0; i < 64; i++) begin
      mem_model[i] = '0;
    end

    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;

    while (retired < NUM_INSTR) begin
      @(posedge clk);
      if (held && !out_valid_o) begin
        stop_on_error("result was dropped while held under back-pressure");
      end
      if (out_valid_o) begin
        check_result();
      end
      held = out_valid_o && !out_ready_i;
      if (out_valid_o && out_ready_i) begin
        pop_result();
        retired++;
      end
      if (in_valid_i && in_ready_o) begin
        accepted++;
      end
      if (!in_valid_i || in_ready_o) begin
        if (generated < NUM_INSTR && ({$random(seed)} % 4) != 0) begin
          drive_next_instr();
        end else begin
          in_valid_i <= 1'b0;
        end
      end
      // ready low about a third of the time
      out_ready_i <= ({$random(seed)} % 3) != 0;
    end

    repeat (4) begin
      @(posedge clk);
      if (out_valid_o) extra++;
    end

    if (extra == 0 && accepted == NUM_INSTR && exp_name.size() == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("handshake count mismatch: %0d accepted, %0d retired, %0d extra results",
               accepted, retired, extra);
      $display("TEST FAILED");
      $fatal(1, "count mismatch");
    end
  end

endmodule

`default_nettype wire

// File: build.f
exu_pkg.sv
exu_ifs.sv
exu_alu.sv
exu_csr_file.sv
exu_ctrl_flow.sv
exu_stage.sv
exu_data_mem.sv
exu_top.sv
tb_exu.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_exu -o sim_exu

output=$(./obj_dir/sim_exu 2>&1 || true)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "TEST PASSED"; then
  exit 0
fi
exit 1
